// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  mipsPkg::word_t  srcA,
	input  mipsPkg::word_t  srcB,
	input  logic [4:0]      shamt,
	input  mipsPkg::aluOp_t op,
	output mipsPkg::word_t  result,
	output logic            zero
);

	logic lessThan;

	// Signed compare for slt
	assign lessThan = $signed(srcA) < $signed(srcB);

	always_comb begin
		case (op)
			mipsPkg::aluAdd: result = srcA + srcB;
			mipsPkg::aluSub: result = srcA - srcB;
			mipsPkg::aluAnd: result = srcA & srcB;
			mipsPkg::aluOr:  result = srcA | srcB;
			mipsPkg::aluSlt: result = {31'd0, lessThan};
			// Shift operand is rt, not rs
			mipsPkg::aluSll: result = srcB << shamt;
			mipsPkg::aluLui: result = {srcB[15:0], 16'h0000};
			default:         result = '0;
		endcase
	end

	// Used by beq/bne after the subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller (
	input  mipsPkg::word_t instr,
	ctrlIf.source          ctl
);

	mipsPkg::opcode_t opcode;
	mipsPkg::funct_t funct;

	assign opcode = mipsPkg::opcode_t'(instr[31:26]);
	assign funct = mipsPkg::funct_t'(instr[5:0]);

	////////////////////////////////////////////////////////////////////////
	// Decode table
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Defaults describe a no-op
		ctl.isBranch = 1'b0;
		ctl.branchOnEqual = 1'b0;
		ctl.jump = 1'b0;
		ctl.jumpReg = 1'b0;
		ctl.link = 1'b0;
		ctl.regDstRd = 1'b0;
		ctl.aluSrcImm = 1'b0;
		ctl.wbSel = mipsPkg::wbAlu;
		ctl.extMode = mipsPkg::extSign;
		ctl.aluOp = mipsPkg::aluAdd;
		ctl.regWe = 1'b0;
		ctl.memWe = 1'b0;

		case (opcode)
			mipsPkg::opRType: begin
				ctl.regDstRd = 1'b1;
				ctl.regWe = 1'b1;
				case (funct)
					mipsPkg::fnAddu: ctl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSubu: ctl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd:  ctl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:   ctl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt:  ctl.aluOp = mipsPkg::aluSlt;
					mipsPkg::fnSll:  ctl.aluOp = mipsPkg::aluSll;
					mipsPkg::fnJr: begin
						ctl.jumpReg = 1'b1;
						ctl.regWe = 1'b0;
					end
					default: ctl.regWe = 1'b0;
				endcase
			end
			mipsPkg::opAddiu: begin
				ctl.aluSrcImm = 1'b1;
				ctl.regWe = 1'b1;
			end
			mipsPkg::opOri: begin
				ctl.aluSrcImm = 1'b1;
				ctl.extMode = mipsPkg::extZero;
				ctl.aluOp = mipsPkg::aluOr;
				ctl.regWe = 1'b1;
			end
			mipsPkg::opLui: begin
				ctl.aluSrcImm = 1'b1;
				ctl.extMode = mipsPkg::extZero;
				ctl.aluOp = mipsPkg::aluLui;
				ctl.regWe = 1'b1;
			end
			mipsPkg::opLw: begin
				ctl.aluSrcImm = 1'b1;
				ctl.wbSel = mipsPkg::wbMem;
				ctl.regWe = 1'b1;
			end
			mipsPkg::opSw: begin
				ctl.aluSrcImm = 1'b1;
				ctl.memWe = 1'b1;
			end
			// Compare rs and rt through a subtract
			mipsPkg::opBeq: begin
				ctl.isBranch = 1'b1;
				ctl.branchOnEqual = 1'b1;
				ctl.extMode = mipsPkg::extSignSh2;
				ctl.aluOp = mipsPkg::aluSub;
			end
			mipsPkg::opBne: begin
				ctl.isBranch = 1'b1;
				ctl.extMode = mipsPkg::extSignSh2;
				ctl.aluOp = mipsPkg::aluSub;
			end
			mipsPkg::opJ: ctl.jump = 1'b1;
			mipsPkg::opJal: begin
				ctl.jump = 1'b1;
				ctl.link = 1'b1;
				ctl.wbSel = mipsPkg::wbPc4;
				ctl.regWe = 1'b1;
			end
			default: ;
		endcase
	end

	// No instruction in the subset both stores and writes back
	always_comb begin
		assert (!(ctl.memWe && ctl.regWe))
			else $error("controller: memWe and regWe both set, instr %h", instr);
	end

endmodule

`default_nettype wire

// File: ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded controls from controller to datapath
interface ctrlIf;

	logic isBranch;
	logic branchOnEqual;
	logic jump;
	logic jumpReg;
	logic link;
	logic regDstRd;
	logic aluSrcImm;
	mipsPkg::wbSel_t wbSel;
	mipsPkg::extMode_t extMode;
	mipsPkg::aluOp_t aluOp;
	logic regWe;
	logic memWe;

	modport source (
		output isBranch, branchOnEqual, jump, jumpReg, link, regDstRd, aluSrcImm,
		output wbSel, extMode, aluOp, regWe, memWe
	);

	modport sink (
		input isBranch, branchOnEqual, jump, jumpReg, link, regDstRd, aluSrcImm,
		input wbSel, extMode, aluOp, regWe, memWe
	);

endinterface

`default_nettype wire

// File: datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  logic           clk,
	input  logic           rstN,
	input  mipsPkg::word_t instr,
	ctrlIf.sink            ctl,
	input  mipsPkg::word_t dmRData,
	output mipsPkg::word_t pc,
	output mipsPkg::word_t dmAddr,
	output mipsPkg::word_t dmWData,
	output logic           dmWe
);

	mipsPkg::regAddr_t rs, rt, rd, writeAddr;
	logic [15:0] imm;
	mipsPkg::word_t extImm, pcPlus4, writeData;
	mipsPkg::word_t readDataA, readDataB, aluSrcB, aluResult;
	logic aluZero;
	logic branchTaken;

	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm = instr[15:0];

	////////////////////////////////////////////////////////////////////////
	// Immediate extension
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (ctl.extMode)
			mipsPkg::extZero:    extImm = {16'h0000, imm};
			mipsPkg::extSign:    extImm = {{16{imm[15]}}, imm};
			mipsPkg::extSignSh2: extImm = {{14{imm[15]}}, imm, 2'b00};
			default:             extImm = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////
	// Register file and write-back
	////////////////////////////////////////////////////////////////////////

	// jal links into r31
	assign writeAddr = ctl.link ? 5'd31 : (ctl.regDstRd ? rd : rt);

	always_comb begin
		case (ctl.wbSel)
			mipsPkg::wbMem: writeData = dmRData;
			mipsPkg::wbPc4: writeData = pcPlus4;
			default:        writeData = aluResult;
		endcase
	end

	regFile u_regFile (
		.clk(clk),
		.rstN(rstN),
		.readAddrA(rs),
		.readAddrB(rt),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn(ctl.regWe),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	////////////////////////////////////////////////////////////////////////
	// ALU, branch decision and PC
	////////////////////////////////////////////////////////////////////////

	assign aluSrcB = ctl.aluSrcImm ? extImm : readDataB;

	alu u_alu (
		.srcA(readDataA),
		.srcB(aluSrcB),
		.shamt(instr[10:6]),
		.op(ctl.aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	assign branchTaken = ctl.isBranch & (ctl.branchOnEqual ? aluZero : ~aluZero);

	pcUnit u_pcUnit (
		.clk(clk),
		.rstN(rstN),
		.branchTaken(branchTaken),
		.jump(ctl.jump),
		.jumpReg(ctl.jumpReg),
		.branchOffset(extImm),
		.jumpTarget(instr[25:0]),
		.regTarget(readDataA),
		.pc(pc),
		.pcPlus4(pcPlus4)
	);

	// Data memory side
	assign dmAddr = aluResult;
	assign dmWData = readDataB;
	assign dmWe = ctl.memWe & rstN;

endmodule

`default_nettype wire

// File: files.f
+incdir+.
mipsPkg.sv
ctrlIf.sv
controller.sv
alu.sv
regFile.sv
pcUnit.sv
datapath.sv
mipsCore.sv
tbClock.sv
tbMips.sv

// File: mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input  logic        clk,
	input  logic        rstN,
	output logic [31:0] pc,
	input  logic [31:0] instr,
	output logic [31:0] dmAddr,
	output logic [31:0] dmWData,
	output logic        dmWe,
	input  logic [31:0] dmRData
);

	// Control bundle between decode and datapath
	ctrlIf ctl ();

	controller u_controller (
		.instr(instr),
		.ctl(ctl.source)
	);

	datapath u_datapath (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.ctl(ctl.sink),
		.dmRData(dmRData),
		.pc(pc),
		.dmAddr(dmAddr),
		.dmWData(dmWData),
		.dmWe(dmWe)
	);

endmodule

`default_nettype wire

// File: mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Data and address words
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	////////////////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////////////////

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddiu = 6'h09,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcode_t;

	// Function field of R-type, instr[5:0]
	typedef enum logic [5:0] {
		fnSll  = 6'h00,
		fnJr   = 6'h08,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} funct_t;

	////////////////////////////////////////////////////////////////////////
	// Datapath controls
	////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSll,
		aluLui
	} aluOp_t;

	// Branch offsets come out already scaled to bytes
	typedef enum logic [1:0] {
		extZero,
		extSign,
		extSignSh2
	} extMode_t;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbPc4
	} wbSel_t;

endpackage

`default_nettype wire

// File: mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Core configuration
////////////////////////////////////////////////////////////////////////////

// First fetch address after reset
`define RESET_PC 32'h0000_3000

// General purpose registers, including the hard-wired zero
`define REG_COUNT 32

`endif

// File: pcUnit.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"
`default_nettype none

module pcUnit (
	input  logic           clk,
	input  logic           rstN,
	input  logic           branchTaken,
	input  logic           jump,
	input  logic           jumpReg,
	input  mipsPkg::word_t branchOffset,
	input  logic [25:0]    jumpTarget,
	input  mipsPkg::word_t regTarget,
	output mipsPkg::word_t pc,
	output mipsPkg::word_t pcPlus4
);

	mipsPkg::word_t nextPc;

	assign pcPlus4 = pc + 32'd4;

	// jr wins over j/jal, which win over branches
	always_comb begin
		if (jumpReg)
			nextPc = regTarget;
		else if (jump)
			nextPc = {pcPlus4[31:28], jumpTarget, 2'b00};
		else if (branchTaken)
			nextPc = pcPlus4 + branchOffset;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= `RESET_PC;
		else
			pc <= nextPc;
	end

	// Misaligned fetch means a bad jr target or target math
	assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pcUnit: misaligned pc %h", pc);

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"
`default_nettype none

module regFile (
	input  logic              clk,
	input  logic              rstN,
	input  mipsPkg::regAddr_t readAddrA,
	input  mipsPkg::regAddr_t readAddrB,
	input  mipsPkg::regAddr_t writeAddr,
	input  mipsPkg::word_t    writeData,
	input  logic              writeEn,
	output mipsPkg::word_t    readDataA,
	output mipsPkg::word_t    readDataB
);

	mipsPkg::word_t regs [`REG_COUNT];

	// Register 0 stays at its reset value since writes to it are dropped
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Combinational read ports
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

	assert property (@(posedge clk) (readAddrA == '0) |-> (readDataA == '0))
		else $error("regFile: register 0 reads %h", readDataA);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the MIPS core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbMips -f files.f > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VtbMips > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock, 4 ns period
module tbClock #(
	parameter int halfPeriod = 2
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(halfPeriod) clk = ~clk;

endmodule

`default_nettype wire

// File: tbMips.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"
`default_nettype none

module tbMips;

	localparam int IMEM_WORDS = 128;
	localparam int TIMEOUT_CYCLES = 1000;
	localparam int RANDOM_COUNT = 40;

	logic clk;
	logic rstN;
	logic dmWe;
	logic imemLoaded;
	mipsPkg::word_t pc, instr, dmAddr, dmWData, dmRData;

	// Program image with a test name for every word
	mipsPkg::word_t imem [IMEM_WORDS];
	string tagOf [IMEM_WORDS];
	mipsPkg::word_t prog [$];
	string progTags [$];
	string curTag;

	mipsPkg::word_t dmem [mipsPkg::word_t];
	int memEpoch;

	// Architectural model state
	mipsPkg::word_t refRegs [`REG_COUNT];
	mipsPkg::word_t refMem [mipsPkg::word_t];
	mipsPkg::word_t refPc, haltPc;
	logic haltSeen;
	int pcErrors, storeErrors, otherErrors;

	tbClock u_tbClock (.clk(clk));

	mipsCore u_mipsCore (
		.clk(clk),
		.rstN(rstN),
		.pc(pc),
		.instr(instr),
		.dmAddr(dmAddr),
		.dmWData(dmWData),
		.dmWe(dmWe),
		.dmRData(dmRData)
	);

	////////////////////////////////////////////////////////////////////////////
	// Assembler and memory helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic mipsPkg::word_t rFormat(input mipsPkg::funct_t fn,
			input mipsPkg::regAddr_t rd, input mipsPkg::regAddr_t rs,
			input mipsPkg::regAddr_t rt, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic mipsPkg::word_t iFormat(input mipsPkg::opcode_t op,
			input mipsPkg::regAddr_t rt, input mipsPkg::regAddr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mipsPkg::word_t jFormat(input mipsPkg::opcode_t op,
			input mipsPkg::word_t target);
		return {op, target[27:2]};
	endfunction

	// Unwritten data words get a pattern unique to their address
	function automatic mipsPkg::word_t fillWord(input mipsPkg::word_t addr);
		return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
	endfunction

	function automatic mipsPkg::word_t fetchWord(input mipsPkg::word_t addr);
		mipsPkg::word_t offset;
		offset = addr - `RESET_PC;
		if (offset < 32'(IMEM_WORDS * 4))
			return imem[offset[8:2]];
		return '0;
	endfunction

	function automatic string tagAt(input mipsPkg::word_t addr);
		mipsPkg::word_t offset;
		offset = addr - `RESET_PC;
		if (offset < 32'(IMEM_WORDS * 4))
			return tagOf[offset[8:2]];
		return "outside";
	endfunction

	function automatic mipsPkg::word_t nextAddr();
		return `RESET_PC + 32'(4 * prog.size());
	endfunction

	task automatic emit(input mipsPkg::word_t word);
		prog.push_back(word);
		progTags.push_back(curTag);
	endtask

	// Combinational memories
	always @(pc or imemLoaded) instr = fetchWord(pc);
	always @(dmAddr or memEpoch or imemLoaded)
		dmRData = dmem.exists(dmAddr) ? dmem[dmAddr] : fillWord(dmAddr);

	always @(posedge clk) begin
		if (rstN && dmWe) begin
			dmem[dmAddr] = dmWData;
			memEpoch <= memEpoch + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Program
	////////////////////////////////////////////////////////////////////////////

	task automatic buildProgram();
		logic [15:0] immA, immB, immC;
		mipsPkg::word_t target;
		mipsPkg::regAddr_t rd, rs, rt;
		int pick;
		immA = 16'($urandom);
		immB = 16'($urandom);
		immC = 16'($urandom);
		// A store sits at the reset address while rstN is low
		curTag = "reset";
		emit(iFormat(mipsPkg::opSw, 5'd0, 5'd0, 16'h0100));
		curTag = "alu";
		emit(iFormat(mipsPkg::opOri, 5'd1, 5'd0, 16'h1000));
		emit(iFormat(mipsPkg::opOri, 5'd2, 5'd0, immA));
		emit(iFormat(mipsPkg::opLui, 5'd3, 5'd0, immB));
		emit(iFormat(mipsPkg::opAddiu, 5'd4, 5'd2, immC));
		emit(rFormat(mipsPkg::fnAddu, 5'd5, 5'd3, 5'd4, 5'd0));
		emit(rFormat(mipsPkg::fnSubu, 5'd6, 5'd2, 5'd5, 5'd0));
		emit(rFormat(mipsPkg::fnAnd, 5'd7, 5'd5, 5'd6, 5'd0));
		emit(rFormat(mipsPkg::fnOr, 5'd8, 5'd7, 5'd3, 5'd0));
		emit(rFormat(mipsPkg::fnSlt, 5'd9, 5'd6, 5'd2, 5'd0));
		emit(rFormat(mipsPkg::fnSlt, 5'd10, 5'd2, 5'd6, 5'd0));
		emit(rFormat(mipsPkg::fnSll, 5'd11, 5'd0, 5'd5, 5'(($urandom % 31) + 1)));
		// Write to r0 must vanish
		emit(iFormat(mipsPkg::opAddiu, 5'd0, 5'd2, immC));
		for (int r = 0; r <= 11; r++)
			emit(iFormat(mipsPkg::opSw, 5'(r), 5'd1, 16'(4 * r)));
		curTag = "load";
		emit(iFormat(mipsPkg::opOri, 5'd12, 5'd0, 16'h1100));
		emit(iFormat(mipsPkg::opLw, 5'd13, 5'd12, 16'h0008));
		emit(iFormat(mipsPkg::opSw, 5'd13, 5'd1, 16'h0040));
		emit(iFormat(mipsPkg::opLw, 5'd14, 5'd12, 16'hfff4));
		emit(iFormat(mipsPkg::opSw, 5'd14, 5'd1, 16'h0044));
		emit(iFormat(mipsPkg::opLw, 5'd15, 5'd1, 16'h000c));
		emit(iFormat(mipsPkg::opSw, 5'd15, 5'd1, 16'h0048));
		curTag = "branch";
		emit(iFormat(mipsPkg::opBeq, 5'd2, 5'd2, 16'h0001));
		emit(iFormat(mipsPkg::opAddiu, 5'd20, 5'd0, 16'h0001));
		emit(iFormat(mipsPkg::opBne, 5'd2, 5'd2, 16'h0001));
		emit(iFormat(mipsPkg::opAddiu, 5'd21, 5'd0, 16'h0002));
		emit(iFormat(mipsPkg::opBeq, 5'd21, 5'd0, 16'h0001));
		emit(iFormat(mipsPkg::opOri, 5'd22, 5'd0, 16'h0003));
		// Countdown loop closed by a backward bne
		emit(iFormat(mipsPkg::opAddiu, 5'd22, 5'd22, 16'hffff));
		emit(iFormat(mipsPkg::opBne, 5'd0, 5'd22, 16'hfffe));
		emit(iFormat(mipsPkg::opSw, 5'd21, 5'd1, 16'h004c));
		curTag = "jump";
		target = nextAddr() + 32'd16;
		emit(jFormat(mipsPkg::opJal, target));
		emit(iFormat(mipsPkg::opSw, 5'd31, 5'd1, 16'h0050));
		target = nextAddr() + 32'd16;
		emit(jFormat(mipsPkg::opJ, target));
		emit(iFormat(mipsPkg::opAddiu, 5'd23, 5'd0, 16'h0007));
		// Subroutine body
		emit(iFormat(mipsPkg::opSw, 5'd31, 5'd1, 16'h0054));
		emit(rFormat(mipsPkg::fnJr, 5'd0, 5'd31, 5'd0, 5'd0));
		curTag = "random";
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			pick = int'($urandom % 10);
			rd = 5'($urandom % 16);
			rs = 5'($urandom % 16);
			rt = 5'($urandom % 16);
			// r1 holds the store base
			if (rd == 5'd1)
				rd = 5'd0;
			case (pick)
				0: emit(rFormat(mipsPkg::fnAddu, rd, rs, rt, 5'd0));
				1: emit(rFormat(mipsPkg::fnSubu, rd, rs, rt, 5'd0));
				2: emit(rFormat(mipsPkg::fnAnd, rd, rs, rt, 5'd0));
				3: emit(rFormat(mipsPkg::fnOr, rd, rs, rt, 5'd0));
				4: emit(rFormat(mipsPkg::fnSlt, rd, rs, rt, 5'd0));
				5: emit(rFormat(mipsPkg::fnSll, rd, 5'd0, rt, 5'($urandom)));
				6: emit(iFormat(mipsPkg::opAddiu, rd, rs, 16'($urandom)));
				7: emit(iFormat(mipsPkg::opOri, rd, rs, 16'($urandom)));
				8: emit(iFormat(mipsPkg::opLui, rd, 5'd0, 16'($urandom)));
				default: emit(iFormat(mipsPkg::opSw, rt, 5'd1, 16'(($urandom % 64) * 4)));
			endcase
		end
		curTag = "halt";
		haltPc = nextAddr();
		emit(iFormat(mipsPkg::opBeq, 5'd0, 5'd0, 16'hffff));
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : '0;
			tagOf[i] = (i < progTags.size()) ? progTags[i] : "none";
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////////////////////

	// Executes one instruction on the model and returns the next pc
	function automatic mipsPkg::word_t stepModel(input mipsPkg::word_t ins,
			output logic stWe, output mipsPkg::word_t stAddr, output mipsPkg::word_t stData);
		mipsPkg::regAddr_t wAddr;
		mipsPkg::word_t a, b, sImm, memAddr, pc4, nextPc, wVal;
		logic wr;
		a = refRegs[ins[25:21]];
		b = refRegs[ins[20:16]];
		sImm = {{16{ins[15]}}, ins[15:0]};
		memAddr = a + sImm;
		pc4 = refPc + 32'd4;
		nextPc = pc4;
		wr = 1'b1;
		wAddr = ins[20:16];
		wVal = '0;
		stWe = 1'b0;
		stAddr = '0;
		stData = '0;
		case (ins[31:26])
			mipsPkg::opRType: begin
				wAddr = ins[15:11];
				case (ins[5:0])
					mipsPkg::fnAddu: wVal = a + b;
					mipsPkg::fnSubu: wVal = a - b;
					mipsPkg::fnAnd:  wVal = a & b;
					mipsPkg::fnOr:   wVal = a | b;
					mipsPkg::fnSlt:  wVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mipsPkg::fnSll:  wVal = b << ins[10:6];
					mipsPkg::fnJr: begin
						wr = 1'b0;
						nextPc = a;
					end
					default: wr = 1'b0;
				endcase
			end
			mipsPkg::opAddiu: wVal = memAddr;
			mipsPkg::opOri:   wVal = a | {16'h0000, ins[15:0]};
			mipsPkg::opLui:   wVal = {ins[15:0], 16'h0000};
			mipsPkg::opLw:    wVal = refMem.exists(memAddr) ? refMem[memAddr] : fillWord(memAddr);
			mipsPkg::opSw: begin
				wr = 1'b0;
				stWe = 1'b1;
				stAddr = memAddr;
				stData = b;
				refMem[memAddr] = b;
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				wr = 1'b0;
				if ((a == b) == (ins[31:26] == mipsPkg::opBeq))
					nextPc = pc4 + {sImm[29:0], 2'b00};
			end
			mipsPkg::opJ, mipsPkg::opJal: begin
				wr = (ins[31:26] == mipsPkg::opJal);
				wAddr = 5'd31;
				wVal = pc4;
				nextPc = {pc4[31:28], ins[25:0], 2'b00};
			end
			default: wr = 1'b0;
		endcase
		if (wr && wAddr != 5'd0)
			refRegs[wAddr] = wVal;
		return nextPc;
	endfunction

	task automatic checkPc(input string name, input mipsPkg::word_t expPc,
			input mipsPkg::word_t actPc);
		if (actPc !== expPc) begin
			pcErrors++;
			$display("FAILED %s pc: expected %h, actual %h", name, expPc, actPc);
		end
	endtask

	task automatic checkStore(input string name, input logic expWe,
			input mipsPkg::word_t expAddr, input mipsPkg::word_t expData,
			input logic actWe, input mipsPkg::word_t actAddr, input mipsPkg::word_t actData);
		if (expWe && actWe !== 1'b1) begin
			storeErrors++;
			$display("ERROR %s: the core did not raise dmWe for a store to %h", name, expAddr);
		end else if (!expWe && actWe !== 1'b0) begin
			storeErrors++;
			$display("ERROR %s: the core raised dmWe on an instruction that stores nothing", name);
		end else if (expWe && (actAddr !== expAddr || actData !== expData)) begin
			storeErrors++;
			$display("FAILED %s store: expected %h <- %h, actual %h <- %h",
				name, expAddr, expData, actAddr, actData);
		end
	endtask

	// Outputs are settled mid-cycle
	always @(negedge clk) begin : compareModel
		mipsPkg::word_t ins, nextPc, stAddr, stData;
		logic stWe;
		string name;
		if (!rstN) begin
			if (dmWe !== 1'b0) begin
				otherErrors++;
				$display("ERROR: dmWe is not low while reset is asserted");
			end
			checkPc("reset", `RESET_PC, pc);
		end else if (!haltSeen) begin
			name = tagAt(refPc);
			ins = fetchWord(refPc);
			checkPc(name, refPc, pc);
			nextPc = stepModel(ins, stWe, stAddr, stData);
			checkStore(name, stWe, stAddr, stData, dmWe, dmAddr, dmWData);
			if (refPc == haltPc)
				haltSeen = 1'b1;
			refPc = nextPc;
		end
	end

	initial begin : mainSequence
		int cycles;
		rstN = 1'b0;
		haltSeen = 1'b0;
		imemLoaded = 1'b0;
		pcErrors = 0;
		storeErrors = 0;
		otherErrors = 0;
		void'($urandom(81));
		buildProgram();
		refPc = `RESET_PC;
		for (int i = 0; i < `REG_COUNT; i++)
			refRegs[i] = '0;
		imemLoaded = 1'b1;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		cycles = 0;
		while (!haltSeen && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (!haltSeen) begin
			otherErrors++;
			$display("ERROR: timeout, the program did not reach its halt loop in %0d cycles",
				TIMEOUT_CYCLES);
		end
		$display("Error counts: pc %0d, store %0d, other %0d", pcErrors, storeErrors, otherErrors);
		if (pcErrors + storeErrors + otherErrors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
